//--- Makefile
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
src/rv_isa_pkg.sv
src/rv_bus_pkg.sv
src/rv_fetch.sv
src/rv_id_stage.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
testbench/rv_core_assert.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- src/rv_alu.sv
// Integer ALU
// Add/sub, logic, shifts, set-less-than and branch comparisons

`timescale 1ns/1ps

module rv_alu (
  input  rv_isa_pkg::id_ctrl_t          ctrl_i,
  output logic [rv_isa_pkg::XLEN-1:0]   result_o,
  output logic                          branch_taken_o
);

  logic [rv_isa_pkg::XLEN-1:0] a, b;
  logic [4:0]                  shamt;
  logic                        eq, lt_s, lt_u;

  assign a     = ctrl_i.op_a;
  assign b     = ctrl_i.op_b;
  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  always_comb begin
    result_o       = '0;
    branch_taken_o = 1'b0;
    unique case (ctrl_i.alu_op)
      rv_isa_pkg::ALU_ADD:  result_o = a + b;
      rv_isa_pkg::ALU_SUB:  result_o = a - b;
      rv_isa_pkg::ALU_AND:  result_o = a & b;
      rv_isa_pkg::ALU_OR:   result_o = a | b;
      rv_isa_pkg::ALU_XOR:  result_o = a ^ b;
      rv_isa_pkg::ALU_SLL:  result_o = a << shamt;
      rv_isa_pkg::ALU_SRL:  result_o = a >> shamt;
      rv_isa_pkg::ALU_SRA:  result_o = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::ALU_SLT:  result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_s};
      rv_isa_pkg::ALU_SLTU: result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_u};
      // Branch decisions
      rv_isa_pkg::ALU_EQ:   branch_taken_o = eq;
      rv_isa_pkg::ALU_NE:   branch_taken_o = ~eq;
      rv_isa_pkg::ALU_LT:   branch_taken_o = lt_s;
      rv_isa_pkg::ALU_GE:   branch_taken_o = ~lt_s;
      rv_isa_pkg::ALU_LTU:  branch_taken_o = lt_u;
      rv_isa_pkg::ALU_GEU:  branch_taken_o = ~lt_u;
      default: ;
    endcase
  end

endmodule

//--- src/rv_bus_pkg.sv
// Memory bus types
// Request and response of the req/gnt/rvalid bus used for fetch and data

package rv_bus_pkg;

  // Master to memory
  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [rv_isa_pkg::XLEN-1:0] addr;
    logic [rv_isa_pkg::XLEN-1:0] wdata;
  } bus_req_t;

  // Memory to master
  typedef struct packed {
    logic                        gnt;
    logic                        rvalid;
    logic [rv_isa_pkg::XLEN-1:0] rdata;
  } bus_rsp_t;

endpackage

//--- src/rv_core.sv
// RV32I core top level
// Multi-cycle core with fetch, decode/control, register file, ALU and LSU

`timescale 1ns/1ps

module rv_core #(
  parameter logic [rv_isa_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                 clk,
  input  logic                 rst_ni,
  output rv_bus_pkg::bus_req_t instr_bus_o,
  input  rv_bus_pkg::bus_rsp_t instr_bus_i,
  output rv_bus_pkg::bus_req_t data_bus_o,
  input  rv_bus_pkg::bus_rsp_t data_bus_i
);

  // Fetch and decode
  logic                            instr_valid;
  logic [rv_isa_pkg::XLEN-1:0]     instr;
  logic [rv_isa_pkg::XLEN-1:0]     pc;
  logic                            fetch_next;
  logic                            pc_set;
  logic [rv_isa_pkg::XLEN-1:0]     target;

  // Register file
  logic [rv_isa_pkg::RegAddrW-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [rv_isa_pkg::XLEN-1:0]     rs1_data, rs2_data, rd_wdata;
  logic                            rd_we;

  // Execute and memory
  rv_isa_pkg::id_ctrl_t            id_ctrl;
  logic [rv_isa_pkg::XLEN-1:0]     alu_result;
  logic                            branch_taken;
  logic                            lsu_start, lsu_we, lsu_done;
  logic [rv_isa_pkg::XLEN-1:0]     lsu_addr, lsu_wdata, lsu_rdata;

  rv_fetch #(
    .BootAddr ( BootAddr )
  ) fetch_i (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .fetch_next_i  ( fetch_next  ),
    .pc_set_i      ( pc_set      ),
    .target_i      ( target      ),
    .instr_bus_o   ( instr_bus_o ),
    .instr_bus_i   ( instr_bus_i ),
    .instr_valid_o ( instr_valid ),
    .instr_o       ( instr       ),
    .pc_o          ( pc          )
  );

  rv_id_stage id_stage_i (
    .clk            ( clk          ),
    .rst_ni         ( rst_ni       ),
    .instr_valid_i  ( instr_valid  ),
    .instr_i        ( instr        ),
    .pc_i           ( pc           ),
    .rs1_addr_o     ( rs1_addr     ),
    .rs2_addr_o     ( rs2_addr     ),
    .rs1_data_i     ( rs1_data     ),
    .rs2_data_i     ( rs2_data     ),
    .rd_we_o        ( rd_we        ),
    .rd_addr_o      ( rd_addr      ),
    .rd_wdata_o     ( rd_wdata     ),
    .ctrl_o         ( id_ctrl      ),
    .alu_result_i   ( alu_result   ),
    .branch_taken_i ( branch_taken ),
    .lsu_start_o    ( lsu_start    ),
    .lsu_addr_o     ( lsu_addr     ),
    .lsu_we_o       ( lsu_we       ),
    .lsu_wdata_o    ( lsu_wdata    ),
    .lsu_done_i     ( lsu_done     ),
    .lsu_rdata_i    ( lsu_rdata    ),
    .fetch_next_o   ( fetch_next   ),
    .pc_set_o       ( pc_set       ),
    .target_o       ( target       )
  );

  rv_regfile regfile_i (
    .clk       ( clk      ),
    .rst_ni    ( rst_ni   ),
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( rd_we    ),
    .waddr_i   ( rd_addr  ),
    .wdata_i   ( rd_wdata )
  );

  rv_alu alu_i (
    .ctrl_i         ( id_ctrl      ),
    .result_o       ( alu_result   ),
    .branch_taken_o ( branch_taken )
  );

  rv_lsu lsu_i (
    .clk        ( clk        ),
    .rst_ni     ( rst_ni     ),
    .start_i    ( lsu_start  ),
    .addr_i     ( lsu_addr   ),
    .we_i       ( lsu_we     ),
    .wdata_i    ( lsu_wdata  ),
    .data_bus_o ( data_bus_o ),
    .data_bus_i ( data_bus_i ),
    .done_o     ( lsu_done   ),
    .rdata_o    ( lsu_rdata  )
  );

endmodule

//--- src/rv_fetch.sv
// Instruction fetch
// Keeps the PC, fetches one word per fetch_next and holds it for decode

`timescale 1ns/1ps

module rv_fetch #(
  parameter logic [rv_isa_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                          clk,
  input  logic                          rst_ni,
  input  logic                          fetch_next_i,
  input  logic                          pc_set_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   target_i,
  output rv_bus_pkg::bus_req_t          instr_bus_o,
  input  rv_bus_pkg::bus_rsp_t          instr_bus_i,
  output logic                          instr_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]   instr_o,
  output logic [rv_isa_pkg::XLEN-1:0]   pc_o
);

  typedef enum logic [1:0] {
    FETCH_BOOT, FETCH_REQ, FETCH_WAIT, FETCH_VALID
  } fetch_state_e;

  fetch_state_e                state_q;
  logic [rv_isa_pkg::XLEN-1:0] pc_q;
  logic [rv_isa_pkg::XLEN-1:0] instr_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_BOOT;
      pc_q    <= BootAddr;
    end else begin
      unique case (state_q)
        FETCH_BOOT: state_q <= FETCH_REQ;
        FETCH_REQ: begin
          if (instr_bus_i.gnt) state_q <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (instr_bus_i.rvalid) state_q <= FETCH_VALID;
        end
        FETCH_VALID: begin
          if (fetch_next_i) begin
            state_q <= FETCH_REQ;
            pc_q    <= pc_set_i ? target_i : pc_q + 32'd4;
          end
        end
        default: state_q <= FETCH_BOOT;
      endcase
    end
  end

  // Instruction word, valid from the cycle after rvalid
  always_ff @(posedge clk) begin
    if (state_q == FETCH_WAIT && instr_bus_i.rvalid) begin
      instr_q <= instr_bus_i.rdata;
    end
  end

  assign instr_bus_o.req   = (state_q == FETCH_REQ);
  assign instr_bus_o.we    = 1'b0;
  assign instr_bus_o.addr  = pc_q;
  assign instr_bus_o.wdata = '0;

  assign instr_valid_o = (state_q == FETCH_VALID);
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

endmodule

//--- src/rv_id_stage.sv
// Decode and control
// Builds operands and control from the fetched word, selects writeback
// and next PC, and sequences loads and stores through the LSU

`timescale 1ns/1ps

module rv_id_stage (
  input  logic                              clk,
  input  logic                              rst_ni,
  input  logic                              instr_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       pc_i,
  output logic [rv_isa_pkg::RegAddrW-1:0]   rs1_addr_o,
  output logic [rv_isa_pkg::RegAddrW-1:0]   rs2_addr_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data_i,
  output logic                              rd_we_o,
  output logic [rv_isa_pkg::RegAddrW-1:0]   rd_addr_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rd_wdata_o,
  output rv_isa_pkg::id_ctrl_t              ctrl_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       alu_result_i,
  input  logic                              branch_taken_i,
  output logic                              lsu_start_o,
  output logic [rv_isa_pkg::XLEN-1:0]       lsu_addr_o,
  output logic                              lsu_we_o,
  output logic [rv_isa_pkg::XLEN-1:0]       lsu_wdata_o,
  input  logic                              lsu_done_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       lsu_rdata_i,
  output logic                              fetch_next_o,
  output logic                              pc_set_o,
  output logic [rv_isa_pkg::XLEN-1:0]       target_o
);

  typedef enum logic {ID_EXEC, ID_MEM_WAIT} id_state_e;

  id_state_e                   state_q;
  rv_isa_pkg::opcode_e         opcode;
  logic [2:0]                  funct3;
  logic [rv_isa_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [rv_isa_pkg::XLEN-1:0] pc_plus4;
  logic                        mem_op;
  logic                        exec_now;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  assign opcode     = rv_isa_pkg::opcode_e'(instr_i[6:0]);
  assign funct3     = instr_i[14:12];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_o            = '0;
    ctrl_o.alu_op     = rv_isa_pkg::ALU_ADD;
    ctrl_o.op_a       = rs1_data_i;
    ctrl_o.op_b       = rs2_data_i;
    ctrl_o.rd_addr    = instr_i[11:7];
    ctrl_o.store_data = rs2_data_i;
    // Anything not listed falls through as a no-op
    unique case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        ctrl_o.op_a  = '0;
        ctrl_o.op_b  = imm_u;
        ctrl_o.rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        ctrl_o.op_a  = pc_i;
        ctrl_o.op_b  = imm_u;
        ctrl_o.rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        ctrl_o.jump  = 1'b1;
        ctrl_o.rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        ctrl_o.op_b  = imm_i;
        ctrl_o.jump  = 1'b1;
        ctrl_o.rd_we = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        ctrl_o.branch = 1'b1;
        unique case (funct3)
          3'b000:  ctrl_o.alu_op = rv_isa_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_op = rv_isa_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_op = rv_isa_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_op = rv_isa_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_op = rv_isa_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_op = rv_isa_pkg::ALU_GEU;
          default: ctrl_o.branch = 1'b0;
        endcase
      end
      rv_isa_pkg::OPC_LOAD: begin
        ctrl_o.op_b  = imm_i;
        ctrl_o.load  = (funct3 == 3'b010);
        ctrl_o.rd_we = (funct3 == 3'b010);
      end
      rv_isa_pkg::OPC_STORE: begin
        ctrl_o.op_b  = imm_s;
        ctrl_o.store = (funct3 == 3'b010);
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
        ctrl_o.rd_we = 1'b1;
        if (opcode == rv_isa_pkg::OPC_OP_IMM) ctrl_o.op_b = imm_i;
        unique case (funct3)
          3'b000: begin
            // SUB only exists in the register form
            if (opcode == rv_isa_pkg::OPC_OP && instr_i[30]) begin
              ctrl_o.alu_op = rv_isa_pkg::ALU_SUB;
            end
          end
          3'b001:  ctrl_o.alu_op = rv_isa_pkg::ALU_SLL;
          3'b010:  ctrl_o.alu_op = rv_isa_pkg::ALU_SLT;
          3'b011:  ctrl_o.alu_op = rv_isa_pkg::ALU_SLTU;
          3'b100:  ctrl_o.alu_op = rv_isa_pkg::ALU_XOR;
          3'b101:  ctrl_o.alu_op = instr_i[30] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
          3'b110:  ctrl_o.alu_op = rv_isa_pkg::ALU_OR;
          default: ctrl_o.alu_op = rv_isa_pkg::ALU_AND;
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  assign mem_op   = ctrl_o.load | ctrl_o.store;
  assign exec_now = (state_q == ID_EXEC) & instr_valid_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ID_EXEC;
    end else if (exec_now && mem_op) begin
      state_q <= ID_MEM_WAIT;
    end else if (state_q == ID_MEM_WAIT && lsu_done_i) begin
      state_q <= ID_EXEC;
    end
  end

  assign lsu_start_o = exec_now & mem_op;
  assign lsu_addr_o  = alu_result_i;
  assign lsu_we_o    = ctrl_o.store;
  assign lsu_wdata_o = ctrl_o.store_data;

  assign fetch_next_o = (exec_now & ~mem_op) | ((state_q == ID_MEM_WAIT) & lsu_done_i);

  // Writeback
  assign pc_plus4  = pc_i + 32'd4;
  assign rd_addr_o = ctrl_o.rd_addr;
  assign rd_we_o   = (exec_now & ~mem_op & ctrl_o.rd_we) |
                     ((state_q == ID_MEM_WAIT) & lsu_done_i & ctrl_o.load);

  always_comb begin
    if (ctrl_o.jump) begin
      rd_wdata_o = pc_plus4;
    end else if (ctrl_o.load) begin
      rd_wdata_o = lsu_rdata_i;
    end else begin
      rd_wdata_o = alu_result_i;
    end
  end

  // Next PC
  assign pc_set_o = ctrl_o.jump | (ctrl_o.branch & branch_taken_i);

  always_comb begin
    if (opcode == rv_isa_pkg::OPC_JALR) begin
      target_o = {alu_result_i[rv_isa_pkg::XLEN-1:1], 1'b0};
    end else if (opcode == rv_isa_pkg::OPC_JAL) begin
      target_o = pc_i + imm_j;
    end else begin
      target_o = pc_i + imm_b;
    end
  end

endmodule

//--- src/rv_isa_pkg.sv
// RV32I instruction set definitions
// Major opcodes, ALU operations and the decoded control word

package rv_isa_pkg;

  parameter int unsigned XLEN     = 32;
  parameter int unsigned RegAddrW = 5;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Decode to execute
  typedef struct packed {
    alu_op_e             alu_op;
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [RegAddrW-1:0] rd_addr;
    logic                rd_we;
    logic                load;
    logic                store;
    logic                branch;
    logic                jump;
    logic [XLEN-1:0]     store_data;
  } id_ctrl_t;

endpackage

//--- src/rv_lsu.sv
// Load/store unit
// Runs one word access on the data bus per start pulse

`timescale 1ns/1ps

module rv_lsu (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [rv_isa_pkg::XLEN-1:0] addr_i,
  input  logic                        we_i,
  input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
  output rv_bus_pkg::bus_req_t        data_bus_o,
  input  rv_bus_pkg::bus_rsp_t        data_bus_i,
  output logic                        done_o,
  output logic [rv_isa_pkg::XLEN-1:0] rdata_o
);

  typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_WAIT} lsu_state_e;

  lsu_state_e                  state_q;
  logic [rv_isa_pkg::XLEN-1:0] addr_q;
  logic [rv_isa_pkg::XLEN-1:0] wdata_q;
  logic                        we_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
    end else begin
      unique case (state_q)
        LSU_IDLE: if (start_i) state_q <= LSU_REQ;
        LSU_REQ:  if (data_bus_i.gnt) state_q <= LSU_WAIT;
        LSU_WAIT: if (data_bus_i.rvalid) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  // Request payload stays stable until the grant
  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && start_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
  end

  assign data_bus_o.req   = (state_q == LSU_REQ);
  assign data_bus_o.we    = we_q;
  assign data_bus_o.addr  = addr_q;
  assign data_bus_o.wdata = wdata_q;

  assign done_o  = (state_q == LSU_WAIT) & data_bus_i.rvalid;
  assign rdata_o = data_bus_i.rdata;

endmodule

//--- src/rv_regfile.sv
// Integer register file
// x1..x31 with two combinational reads and one write, x0 reads as zero

`timescale 1ns/1ps

module rv_regfile (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic [rv_isa_pkg::RegAddrW-1:0] raddr_a_i,
  input  logic [rv_isa_pkg::RegAddrW-1:0] raddr_b_i,
  output logic [rv_isa_pkg::XLEN-1:0]     rdata_a_o,
  output logic [rv_isa_pkg::XLEN-1:0]     rdata_b_o,
  input  logic                            we_i,
  input  logic [rv_isa_pkg::RegAddrW-1:0] waddr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]     wdata_i
);

  logic [rv_isa_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- testbench/program_patterns.txt
# Columns: kind address word (hex), text after the word is ignored
# I = instruction, D = initial data word, E = expected store in program order
I 00000000 10000513 addi x10,x0,0x100
I 00000004 20000593 addi x11,x0,0x200
I 00000008 123450b7 lui x1,0x12345
I 0000000c 67808093 addi x1,x1,0x678
I 00000010 00152023 sw x1,0(x10)
I 00000014 00001117 auipc x2,1
I 00000018 00252223 sw x2,4(x10)
I 0000001c ffb00193 addi x3,x0,-5
I 00000020 4011d213 srai x4,x3,1
I 00000024 01c1d293 srli x5,x3,28
I 00000028 40328333 sub x6,x5,x3
I 0000002c 0030c3b3 xor x7,x1,x3
I 00000030 0051a433 slt x8,x3,x5
I 00000034 0051b4b3 sltu x9,x3,x5
I 00000038 00529633 sll x12,x5,x5
I 0000003c 00c206b3 add x13,x4,x12
I 00000040 00752423 sw x7,8(x10)
I 00000044 00d52623 sw x13,12(x10)
I 00000048 00841713 slli x14,x8,8
I 0000004c 00976733 or x14,x14,x9
I 00000050 00670733 add x14,x14,x6
I 00000054 00e52823 sw x14,16(x10)
I 00000058 00840463 beq x8,x8,+8 taken
I 0000005c 00178793 addi x15,x15,1
I 00000060 00519463 bne x3,x5,+8 taken
I 00000064 00278793 addi x15,x15,2
I 00000068 0032c463 blt x5,x3,+8 not taken
I 0000006c 00478793 addi x15,x15,4
I 00000070 0051d463 bge x3,x5,+8 not taken
I 00000074 00878793 addi x15,x15,8
I 00000078 0032e463 bltu x5,x3,+8 taken
I 0000007c 01078793 addi x15,x15,16
I 00000080 0032f463 bgeu x5,x3,+8 not taken
I 00000084 02078793 addi x15,x15,32
I 00000088 00f52a23 sw x15,20(x10)
I 0000008c 0080086f jal x16,+8
I 00000090 04078793 addi x15,x15,64 skipped
I 00000094 01052c23 sw x16,24(x10)
I 00000098 00000897 auipc x17,0
I 0000009c 00d88967 jalr x18,13(x17) lands on 0xa4
I 000000a0 08078793 addi x15,x15,128 skipped
I 000000a4 01252e23 sw x18,28(x10)
I 000000a8 0005a983 lw x19,0(x11)
I 000000ac 0045aa03 lw x20,4(x11)
I 000000b0 01498ab3 add x21,x19,x20
I 000000b4 03552023 sw x21,32(x10)
I 000000b8 02052b03 lw x22,32(x10)
I 000000bc 001b0b13 addi x22,x22,1
I 000000c0 03652223 sw x22,36(x10)
I 000000c4 0f03fb93 andi x23,x7,0xf0
I 000000c8 017b8033 add x0,x23,x23
I 000000cc 01700c33 add x24,x0,x23
I 000000d0 03852423 sw x24,40(x10)
I 000000d4 02052623 sw x0,44(x10)
I 000000d8 02f52823 sw x15,48(x10)
I 000000dc 0000006f jal x0,0
D 00000200 cafef00d
D 00000204 0badbeef
D 00000120 11111111 overwritten before it is read
E 00000100 12345678 lui and addi
E 00000104 00001014 auipc
E 00000108 edcba983 xor
E 0000010c 00077ffd srai, srli, sll, add
E 00000110 00000114 slt, sltu, slli, or, sub
E 00000114 0000002c branch path bits 4+8+32
E 00000118 00000090 jal link
E 0000011c 000000a0 jalr link
E 00000120 d6acaefc sum of two loaded words
E 00000124 d6acaefd load after store
E 00000128 00000080 andi, x0 read as zero
E 0000012c 00000000 store of x0
E 00000130 0000002c jumps skipped their addi

//--- testbench/rv_core_assert.sv
// Bus protocol checks for the core
// Watches the instruction and data buses from inside rv_core

`timescale 1ns/1ps

module rv_core_assert (
  input logic                 clk,
  input logic                 rst_ni,
  input rv_bus_pkg::bus_req_t instr_req_i,
  input rv_bus_pkg::bus_rsp_t instr_rsp_i,
  input rv_bus_pkg::bus_req_t data_req_i,
  input rv_bus_pkg::bus_rsp_t data_rsp_i
);

  // Granted and still waiting for rvalid
  logic instr_pending_q;
  logic data_pending_q;

  // Count of failed checks
  int unsigned fail_cnt;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_pending_q <= 1'b0;
      data_pending_q  <= 1'b0;
    end else begin
      if (instr_req_i.req && instr_rsp_i.gnt) begin
        instr_pending_q <= 1'b1;
      end else if (instr_rsp_i.rvalid) begin
        instr_pending_q <= 1'b0;
      end
      if (data_req_i.req && data_rsp_i.gnt) begin
        data_pending_q <= 1'b1;
      end else if (data_rsp_i.rvalid) begin
        data_pending_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request stable until grant
  ////////////////////////////////////////////////////////////

  instr_hold_a: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i.req && !instr_rsp_i.gnt |=> $stable(instr_req_i))
    else begin
      $error("instruction request changed while waiting for grant");
      fail_cnt++;
    end

  data_hold_a: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_i.req && !data_rsp_i.gnt |=> $stable(data_req_i))
    else begin
      $error("data request changed while waiting for grant");
      fail_cnt++;
    end

  // Quiet buses in reset
  reset_idle_a: assert property (@(posedge clk)
    !rst_ni |-> !instr_req_i.req && !data_req_i.req)
    else begin
      $error("bus request raised during reset");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Response only for a granted request
  ////////////////////////////////////////////////////////////

  instr_rvalid_a: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_rsp_i.rvalid |-> instr_pending_q)
    else begin
      $error("instruction rvalid without an outstanding grant");
      fail_cnt++;
    end

  data_rvalid_a: assert property (@(posedge clk) disable iff (!rst_ni)
    data_rsp_i.rvalid |-> data_pending_q)
    else begin
      $error("data rvalid without an outstanding grant");
      fail_cnt++;
    end

endmodule

bind rv_core rv_core_assert assert_i (
  .clk         ( clk         ),
  .rst_ni      ( rst_ni      ),
  .instr_req_i ( instr_bus_o ),
  .instr_rsp_i ( instr_bus_i ),
  .data_req_i  ( data_bus_o  ),
  .data_rsp_i  ( data_bus_i  )
);

//--- testbench/tb_clock.sv
// Clock and reset source for the testbench
// Free-running clock, active-low reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned ClkPeriod   = 4,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- testbench/tb_top.sv
// Testbench for the RV32I core
// Memory models with random handshake delays, program and expected
// stores from the pattern file, store checking and a cycle limit

`timescale 1ns/1ps

module tb_top;

  localparam logic [31:0] BootAddr      = 32'h0;
  localparam string       PatternFile   = "testbench/program_patterns.txt";
  localparam int          CyclesPerItem = 64;

  logic                 clk;
  logic                 rst_ni;
  rv_bus_pkg::bus_req_t instr_req;
  rv_bus_pkg::bus_rsp_t instr_rsp;
  rv_bus_pkg::bus_req_t data_req;
  rv_bus_pkg::bus_rsp_t data_rsp;

  // Sparse memories, keyed by byte address
  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];

  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  int          n_instr;
  int          n_seen;
  bit          run_ended;

  tb_clock #(
    .ClkPeriod   ( 4  ),
    .ResetCycles ( 16 )
  ) clock0 (
    .clk_o  ( clk    ),
    .rst_no ( rst_ni )
  );

  rv_core #(
    .BootAddr ( BootAddr )
  ) dut0 (
    .clk         ( clk       ),
    .rst_ni      ( rst_ni    ),
    .instr_bus_o ( instr_req ),
    .instr_bus_i ( instr_rsp ),
    .data_bus_o  ( data_req  ),
    .data_bus_i  ( data_rsp  )
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Unwritten words, distinct for every address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[15:0], ~addr[31:16]};
  endfunction

  task automatic fail_run(input string why);
    run_ended = 1'b1;
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  // Advance to the drive point of a later cycle
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] addr;
    logic [31:0] word;
    fd = $fopen(PatternFile, "r");
    assert (fd != 0) else fail_run($sformatf("cannot open %s", PatternFile));
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      kind = line[0];
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
      assert (n == 2) else fail_run($sformatf("malformed pattern line: %s", line));
      assert (kind inside {"I", "D", "E"})
        else fail_run($sformatf("unknown pattern line kind: %s", line));
      case (kind)
        "I": begin
          imem[addr] = word;
          n_instr++;
        end
        "D": dmem[addr] = word;
        "E": begin
          exp_addr_q.push_back(addr);
          exp_data_q.push_back(word);
        end
        default: ;
      endcase
    end
    $fclose(fd);
    assert (n_instr > 0 && exp_addr_q.size() > 0)
      else fail_run("pattern file holds no program or no expected stores");
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] wdata);
    assert (n_seen < exp_addr_q.size())
      else fail_run($sformatf("store of %h to %h at %0t after the last expected store",
                              wdata, addr, $time));
    assert (addr == exp_addr_q[n_seen])
      else fail_run($sformatf("mismatch at %0t: data_bus_o.addr expected %h, got %h",
                              $time, exp_addr_q[n_seen], addr));
    assert (wdata == exp_data_q[n_seen])
      else fail_run($sformatf("mismatch at %0t: data_bus_o.wdata expected %h, got %h",
                              $time, exp_data_q[n_seen], wdata));
    n_seen++;
  endtask

  ////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////

  // Grant after 0 to 3 cycles, rvalid 1 to 3 cycles after grant
  task automatic serve_instr_port();
    logic [31:0] addr;
    instr_rsp = '0;
    forever begin
      step_cycles(1);
      instr_rsp = '0;
      if (rst_ni && instr_req.req) begin
        step_cycles($urandom_range(3, 0));
        addr          = instr_req.addr;
        instr_rsp.gnt = 1'b1;
        step_cycles(1);
        instr_rsp.gnt = 1'b0;
        step_cycles($urandom_range(2, 0));
        instr_rsp.rvalid = 1'b1;
        instr_rsp.rdata  = imem.exists(addr) ? imem[addr] : fill_word(addr);
      end
    end
  endtask

  task automatic serve_data_port();
    logic [31:0] addr;
    logic [31:0] rdata;
    data_rsp = '0;
    forever begin
      step_cycles(1);
      data_rsp = '0;
      if (rst_ni && data_req.req) begin
        step_cycles($urandom_range(3, 0));
        addr = data_req.addr;
        if (data_req.we) begin
          check_store(addr, data_req.wdata);
          dmem[addr] = data_req.wdata;
          rdata      = '0;
        end else begin
          rdata = dmem.exists(addr) ? dmem[addr] : fill_word(addr);
        end
        data_rsp.gnt = 1'b1;
        step_cycles(1);
        data_rsp.gnt = 1'b0;
        step_cycles($urandom_range(2, 0));
        data_rsp.rvalid = 1'b1;
        data_rsp.rdata  = rdata;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin : run_test
    int limit;
    int cycles;
    void'($urandom(95428));
    load_patterns();
    // Both ports draw their delays from the seeded generator
    fork
      serve_instr_port();
      serve_data_port();
    join_none
    limit  = CyclesPerItem * (n_instr + exp_addr_q.size());
    cycles = 0;
    while (n_seen < exp_addr_q.size() && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (n_seen < exp_addr_q.size()) begin
      fail_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, n_seen, exp_addr_q.size()));
    end
    // Core spins in its final loop, a surplus store would still be caught
    repeat (CyclesPerItem) @(posedge clk);
    if (dut0.assert_i.fail_cnt == 0) begin
      run_ended = 1'b1;
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d bus protocol assertions failed", dut0.assert_i.fail_cnt));
    end
  end

  // Run stopped by a bus protocol assertion
  final begin
    if (!run_ended) begin
      $display("Simulation failed");
    end
  end

endmodule
